// File: hw/id_pkg.sv
package id_pkg;

    localparam int REG_W    = 32;
    localparam int RADDR_W  = 5;
    localparam logic [RADDR_W-1:0] LINK_REG = 5'd31;

    // primary opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // SPECIAL function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLL   = 8'b01111100,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_J     = 8'b01001111,
        ALU_JAL   = 8'b01010000,
        ALU_JR    = 8'b00001000,
        ALU_JALR  = 8'b00001001,
        ALU_BEQ   = 8'b01010001,
        ALU_BNE   = 8'b01010010,
        ALU_BGTZ  = 8'b01010100,
        ALU_BLEZ  = 8'b01010011,
        ALU_LB    = 8'b11100000,
        ALU_LW    = 8'b11100011,
        ALU_SW    = 8'b11101011
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110,
        SEL_LOAD_STORE  = 3'b111
    } alu_sel_e;

    typedef struct packed {
        alu_op_e            aluop;
        alu_sel_e           alusel;
        logic               wreg;
        logic [RADDR_W-1:0] wd;
        logic               reg1_read;
        logic [RADDR_W-1:0] reg1_addr;
        logic               reg2_read;
        logic [RADDR_W-1:0] reg2_addr;
        logic [REG_W-1:0]   imm;
    } dec_ctrl_t;

    // result seen from ex or mem
    typedef struct packed {
        logic               wreg;
        logic [RADDR_W-1:0] wd;
        logic [REG_W-1:0]   wdata;
        alu_op_e            aluop;
    } fwd_t;

    typedef struct packed {
        alu_op_e            aluop;
        alu_sel_e           alusel;
        logic [REG_W-1:0]   reg1;
        logic [REG_W-1:0]   reg2;
        logic [RADDR_W-1:0] wd;
        logic               wreg;
        logic [REG_W-1:0]   link_addr;
        logic               is_in_delayslot;
    } id_ex_t;

endpackage

// File: hw/id_decoder.sv
module id_decoder
    import id_pkg::*;
(
    input  logic [REG_W-1:0] inst_i,
    output dec_ctrl_t        ctrl_o
);

    opcode_e            op;
    funct_e             fn;
    logic [RADDR_W-1:0] rs;
    logic [RADDR_W-1:0] rt;
    logic [RADDR_W-1:0] rd;
    logic [15:0]        imm16;
    logic [REG_W-1:0]   imm_sext;
    logic               valid;

    assign op       = opcode_e'(inst_i[31:26]);
    assign fn       = funct_e'(inst_i[5:0]);
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign imm16    = inst_i[15:0];
    assign imm_sext = {{16{imm16[15]}}, imm16};

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.wd        = rd;
        ctrl_o.reg1_addr = rs;
        ctrl_o.reg2_addr = rt;
        valid            = 1'b1;

        case (op)
            OP_SPECIAL: begin
                // R-type: rs op rt -> rd unless changed below
                ctrl_o.wreg      = 1'b1;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.reg2_read = 1'b1;
                case (fn)
                    FN_AND:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_AND, SEL_LOGIC};
                    FN_OR:   {ctrl_o.aluop, ctrl_o.alusel} = {ALU_OR, SEL_LOGIC};
                    FN_XOR:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_XOR, SEL_LOGIC};
                    FN_NOR:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_NOR, SEL_LOGIC};
                    FN_SLLV: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLL, SEL_SHIFT};
                    FN_SRLV: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SRL, SEL_SHIFT};
                    FN_SRAV: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SRA, SEL_SHIFT};
                    FN_ADD:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_ADD, SEL_ARITH};
                    FN_ADDU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_ADDU, SEL_ARITH};
                    FN_SUB:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SUB, SEL_ARITH};
                    FN_SUBU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SUBU, SEL_ARITH};
                    FN_SLT:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLT, SEL_ARITH};
                    FN_SLTU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLTU, SEL_ARITH};
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl_o.alusel    = SEL_SHIFT;
                        ctrl_o.aluop     = (fn == FN_SLL) ? ALU_SLL :
                                           (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                        ctrl_o.reg1_read = 1'b0;                  // shamt goes in as reg1
                        ctrl_o.imm       = {27'b0, inst_i[10:6]};
                    end
                    FN_JR, FN_JALR: begin
                        ctrl_o.aluop     = (fn == FN_JR) ? ALU_JR : ALU_JALR;
                        ctrl_o.alusel    = SEL_JUMP_BRANCH;
                        ctrl_o.wreg      = (fn == FN_JALR);       // jalr links into rd
                        ctrl_o.reg2_read = 1'b0;
                    end
                    default: valid = 1'b0;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_o.alusel    = SEL_LOGIC;
                ctrl_o.aluop     = (op == OP_ANDI) ? ALU_AND :
                                   (op == OP_XORI) ? ALU_XOR : ALU_OR;
                ctrl_o.wreg      = 1'b1;
                ctrl_o.wd        = rt;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.imm       = (op == OP_LUI) ? {imm16, 16'h0} : {16'h0, imm16};
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl_o.alusel    = SEL_ARITH;
                ctrl_o.aluop     = (op == OP_ADDI)  ? ALU_ADDI  :
                                   (op == OP_ADDIU) ? ALU_ADDIU :
                                   (op == OP_SLTI)  ? ALU_SLT   : ALU_SLTU;
                ctrl_o.wreg      = 1'b1;
                ctrl_o.wd        = rt;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.imm       = imm_sext;
            end
            OP_J, OP_JAL: begin
                ctrl_o.alusel = SEL_JUMP_BRANCH;
                ctrl_o.aluop  = (op == OP_J) ? ALU_J : ALU_JAL;
                ctrl_o.wreg   = (op == OP_JAL);
                ctrl_o.wd     = LINK_REG;
                ctrl_o.imm    = {6'b0, inst_i[25:0]};   // jump index
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
                ctrl_o.alusel    = SEL_JUMP_BRANCH;
                ctrl_o.aluop     = (op == OP_BEQ) ? ALU_BEQ :
                                   (op == OP_BNE) ? ALU_BNE :
                                   (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.reg2_read = (op == OP_BEQ) || (op == OP_BNE);
                ctrl_o.imm       = imm_sext;            // branch offset
            end
            OP_LB, OP_LW, OP_SW: begin
                ctrl_o.alusel    = SEL_LOAD_STORE;
                ctrl_o.aluop     = (op == OP_LB) ? ALU_LB :
                                   (op == OP_LW) ? ALU_LW : ALU_SW;
                ctrl_o.wreg      = (op != OP_SW);
                ctrl_o.wd        = rt;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.reg2_read = (op == OP_SW);       // store data
                ctrl_o.imm       = imm_sext;
            end
            default: valid = 1'b0;
        endcase

        if (!valid) begin
            ctrl_o = '0;
        end

        // a NOP must never ask the register file for anything
        assert (ctrl_o.aluop != ALU_NOP || !(ctrl_o.reg1_read || ctrl_o.reg2_read))
            else $error("id_decoder: read enable set on NOP");
    end

endmodule

// File: hw/id_operand_sel.sv
module id_operand_sel
    import id_pkg::*;
(
    input  dec_ctrl_t        ctrl_i,
    input  logic [REG_W-1:0] rf1_data_i,
    input  logic [REG_W-1:0] rf2_data_i,
    input  fwd_t             ex_fwd_i,
    input  fwd_t             mem_fwd_i,
    output logic [REG_W-1:0] reg1_o,
    output logic [REG_W-1:0] reg2_o,
    output logic             stall_o
);

    logic ex_is_load;
    logic stall1;
    logic stall2;

    // ex beats mem beats regfile, imm when the port is idle
    function automatic logic [REG_W-1:0] pick_operand(
        input logic               rd_en,
        input logic [RADDR_W-1:0] addr,
        input logic [REG_W-1:0]   rf_data,
        input logic [REG_W-1:0]   imm,
        input fwd_t               ex,
        input fwd_t               mem
    );
        if (!rd_en) return imm;
        if (ex.wreg && ex.wd == addr) return ex.wdata;
        if (mem.wreg && mem.wd == addr) return mem.wdata;
        return rf_data;
    endfunction

    assign ex_is_load = (ex_fwd_i.aluop == ALU_LB) || (ex_fwd_i.aluop == ALU_LW);

    assign stall1 = ex_is_load && ctrl_i.reg1_read && (ex_fwd_i.wd == ctrl_i.reg1_addr);
    assign stall2 = ex_is_load && ctrl_i.reg2_read && (ex_fwd_i.wd == ctrl_i.reg2_addr);

    assign reg1_o = pick_operand(ctrl_i.reg1_read, ctrl_i.reg1_addr, rf1_data_i,
                                 ctrl_i.imm, ex_fwd_i, mem_fwd_i);
    assign reg2_o = pick_operand(ctrl_i.reg2_read, ctrl_i.reg2_addr, rf2_data_i,
                                 ctrl_i.imm, ex_fwd_i, mem_fwd_i);

    always_comb begin
        stall_o = stall1 | stall2;   // load data not ready until mem
        assert (!stall_o || ctrl_i.reg1_read || ctrl_i.reg2_read)
            else $error("id_operand_sel: stall without a register read");
    end

endmodule

// File: hw/id_branch_unit.sv
module id_branch_unit
    import id_pkg::*;
(
    input  dec_ctrl_t        ctrl_i,
    input  logic [REG_W-1:0] pc_i,
    input  logic [REG_W-1:0] reg1_i,
    input  logic [REG_W-1:0] reg2_i,
    output logic             branch_flag_o,
    output logic [REG_W-1:0] branch_target_o,
    output logic [REG_W-1:0] link_addr_o,
    output logic             next_in_delayslot_o
);

    logic [REG_W-1:0] pc_plus_4;
    logic [REG_W-1:0] pc_plus_8;
    logic [REG_W-1:0] br_target;
    logic             taken;

    assign pc_plus_4 = pc_i + 32'd4;
    assign pc_plus_8 = pc_i + 32'd8;
    assign br_target = pc_plus_4 + {ctrl_i.imm[29:0], 2'b00};

    always_comb begin
        case (ctrl_i.aluop)
            ALU_BEQ:  taken = (reg1_i == reg2_i);
            ALU_BNE:  taken = (reg1_i != reg2_i);
            ALU_BGTZ: taken = !reg1_i[31] && (reg1_i != '0);
            ALU_BLEZ: taken = reg1_i[31] || (reg1_i == '0);
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        branch_flag_o   = 1'b1;
        branch_target_o = '0;
        link_addr_o     = '0;
        case (ctrl_i.aluop)
            ALU_J, ALU_JAL: branch_target_o = {pc_plus_4[31:28], ctrl_i.imm[25:0], 2'b00};
            ALU_JR, ALU_JALR: branch_target_o = reg1_i;
            default: begin
                branch_flag_o   = taken;
                branch_target_o = taken ? br_target : '0;
            end
        endcase
        if (ctrl_i.aluop == ALU_JAL || ctrl_i.aluop == ALU_JALR) begin
            link_addr_o = pc_plus_8;   // skip the delay slot
        end
    end

    assign next_in_delayslot_o = branch_flag_o;

endmodule

// File: hw/id_ex_reg.sv
module id_ex_reg
    import id_pkg::*;
(
    input  logic             clk,
    input  logic             reset_i,
    input  dec_ctrl_t        ctrl_i,
    input  logic [REG_W-1:0] reg1_i,
    input  logic [REG_W-1:0] reg2_i,
    input  logic [REG_W-1:0] link_addr_i,
    input  logic             is_in_delayslot_i,
    input  logic             stall_i,
    output id_ex_t           id_ex_o
);

    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            id_ex_o <= '0;   // bubble into ex
        end else begin
            id_ex_o.aluop           <= ctrl_i.aluop;
            id_ex_o.alusel          <= ctrl_i.alusel;
            id_ex_o.reg1            <= reg1_i;
            id_ex_o.reg2            <= reg2_i;
            id_ex_o.wd              <= ctrl_i.wd;
            id_ex_o.wreg            <= ctrl_i.wreg;
            id_ex_o.link_addr       <= link_addr_i;
            id_ex_o.is_in_delayslot <= is_in_delayslot_i;
        end
    end

    // a stalled instruction must not reach write-back
    a_stall_bubble: assert property (
        @(posedge clk) disable iff (reset_i) stall_i |=> !id_ex_o.wreg
    ) else $error("id_ex_reg: write enable after stall");

endmodule

// File: hw/id_stage.sv
module id_stage
    import id_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    input  logic [REG_W-1:0]   inst_i,
    input  logic [REG_W-1:0]   pc_i,
    input  logic               is_in_delayslot_i,
    input  fwd_t               ex_fwd_i,
    input  fwd_t               mem_fwd_i,
    input  logic [REG_W-1:0]   rf1_data_i,
    input  logic [REG_W-1:0]   rf2_data_i,
    output logic               rf1_read_o,
    output logic [RADDR_W-1:0] rf1_addr_o,
    output logic               rf2_read_o,
    output logic [RADDR_W-1:0] rf2_addr_o,
    output logic               stall_o,
    output logic               branch_flag_o,
    output logic [REG_W-1:0]   branch_target_o,
    output logic               next_in_delayslot_o,
    output id_ex_t             id_ex_o
);

    dec_ctrl_t        ctrl;
    logic [REG_W-1:0] reg1;
    logic [REG_W-1:0] reg2;
    logic [REG_W-1:0] link_addr;

    assign rf1_read_o = ctrl.reg1_read;
    assign rf1_addr_o = ctrl.reg1_addr;
    assign rf2_read_o = ctrl.reg2_read;
    assign rf2_addr_o = ctrl.reg2_addr;

    id_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    id_operand_sel u_operand_sel (
        .ctrl_i     (ctrl),
        .rf1_data_i (rf1_data_i),
        .rf2_data_i (rf2_data_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .reg1_o     (reg1),
        .reg2_o     (reg2),
        .stall_o    (stall_o)
    );

    id_branch_unit u_branch_unit (
        .ctrl_i              (ctrl),
        .pc_i                (pc_i),
        .reg1_i              (reg1),
        .reg2_i              (reg2),
        .branch_flag_o       (branch_flag_o),
        .branch_target_o     (branch_target_o),
        .link_addr_o         (link_addr),
        .next_in_delayslot_o (next_in_delayslot_o)
    );

    id_ex_reg u_id_ex_reg (
        .clk               (clk),
        .reset_i           (reset_i),
        .ctrl_i            (ctrl),
        .reg1_i            (reg1),
        .reg2_i            (reg2),
        .link_addr_i       (link_addr),
        .is_in_delayslot_i (is_in_delayslot_i),
        .stall_i           (stall_o),
        .id_ex_o           (id_ex_o)
    );

endmodule

// File: bench/id_model.svh
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// expected decode, straight from the MIPS32 field layout
function automatic dec_ctrl_t model_decode(input logic [31:0] inst);
    dec_ctrl_t  c;
    logic [5:0] op;
    logic [5:0] fn;
    op = inst[31:26];
    fn = inst[5:0];
    c = '0;
    c.wd = inst[15:11];
    c.reg1_addr = inst[25:21];
    c.reg2_addr = inst[20:16];
    case (op)
        6'h00: begin
            c.wreg = 1'b1;
            c.reg1_read = 1'b1;
            c.reg2_read = 1'b1;
            case (fn)
                6'h24: {c.aluop, c.alusel} = {ALU_AND, SEL_LOGIC};
                6'h25: {c.aluop, c.alusel} = {ALU_OR, SEL_LOGIC};
                6'h26: {c.aluop, c.alusel} = {ALU_XOR, SEL_LOGIC};
                6'h27: {c.aluop, c.alusel} = {ALU_NOR, SEL_LOGIC};
                6'h04: {c.aluop, c.alusel} = {ALU_SLL, SEL_SHIFT};
                6'h06: {c.aluop, c.alusel} = {ALU_SRL, SEL_SHIFT};
                6'h07: {c.aluop, c.alusel} = {ALU_SRA, SEL_SHIFT};
                6'h20: {c.aluop, c.alusel} = {ALU_ADD, SEL_ARITH};
                6'h21: {c.aluop, c.alusel} = {ALU_ADDU, SEL_ARITH};
                6'h22: {c.aluop, c.alusel} = {ALU_SUB, SEL_ARITH};
                6'h23: {c.aluop, c.alusel} = {ALU_SUBU, SEL_ARITH};
                6'h2A: {c.aluop, c.alusel} = {ALU_SLT, SEL_ARITH};
                6'h2B: {c.aluop, c.alusel} = {ALU_SLTU, SEL_ARITH};
                6'h00, 6'h02, 6'h03: begin
                    c.alusel = SEL_SHIFT;
                    c.aluop = (fn == 6'h00) ? ALU_SLL : (fn == 6'h02) ? ALU_SRL : ALU_SRA;
                    c.reg1_read = 1'b0;
                    c.imm = {27'b0, inst[10:6]};  // shamt
                end
                6'h08, 6'h09: begin
                    c.alusel = SEL_JUMP_BRANCH;
                    c.aluop = (fn == 6'h08) ? ALU_JR : ALU_JALR;
                    c.wreg = (fn == 6'h09);
                    c.reg2_read = 1'b0;
                end
                default: c = '0;
            endcase
        end
        6'h0C, 6'h0D, 6'h0E, 6'h0F: begin
            c.alusel = SEL_LOGIC;
            c.aluop = (op == 6'h0C) ? ALU_AND : (op == 6'h0E) ? ALU_XOR : ALU_OR;
            c.wreg = 1'b1;
            c.wd = inst[20:16];
            c.reg1_read = 1'b1;
            c.imm = (op == 6'h0F) ? {inst[15:0], 16'h0} : {16'h0, inst[15:0]};
        end
        6'h08, 6'h09, 6'h0A, 6'h0B: begin
            c.alusel = SEL_ARITH;
            c.aluop = (op == 6'h08) ? ALU_ADDI : (op == 6'h09) ? ALU_ADDIU :
                      (op == 6'h0A) ? ALU_SLT : ALU_SLTU;
            c.wreg = 1'b1;
            c.wd = inst[20:16];
            c.reg1_read = 1'b1;
            c.imm = {{16{inst[15]}}, inst[15:0]};
        end
        6'h02, 6'h03: begin
            c.alusel = SEL_JUMP_BRANCH;
            c.aluop = (op == 6'h02) ? ALU_J : ALU_JAL;
            c.wreg = (op == 6'h03);
            c.wd = 5'd31;
            c.imm = {6'b0, inst[25:0]};
        end
        6'h04, 6'h05, 6'h06, 6'h07: begin
            c.alusel = SEL_JUMP_BRANCH;
            c.aluop = (op == 6'h04) ? ALU_BEQ : (op == 6'h05) ? ALU_BNE :
                      (op == 6'h07) ? ALU_BGTZ : ALU_BLEZ;
            c.reg1_read = 1'b1;
            c.reg2_read = (op == 6'h04) || (op == 6'h05);
            c.imm = {{16{inst[15]}}, inst[15:0]};
        end
        6'h20, 6'h23, 6'h2B: begin
            c.alusel = SEL_LOAD_STORE;
            c.aluop = (op == 6'h20) ? ALU_LB : (op == 6'h23) ? ALU_LW : ALU_SW;
            c.wreg = (op != 6'h2B);
            c.wd = inst[20:16];
            c.reg1_read = 1'b1;
            c.reg2_read = (op == 6'h2B);
            c.imm = {{16{inst[15]}}, inst[15:0]};
        end
        default: c = '0;
    endcase
    return c;
endfunction

function automatic logic [31:0] model_operand(input logic rd_en, input logic [4:0] addr,
                                              input logic [31:0] rf_val,
                                              input logic [31:0] imm,
                                              input fwd_t ex, input fwd_t mem);
    if (!rd_en) return imm;
    if (ex.wreg && ex.wd == addr) return ex.wdata;
    if (mem.wreg && mem.wd == addr) return mem.wdata;
    return rf_val;
endfunction

function automatic logic model_stall(input dec_ctrl_t c, input fwd_t ex);
    logic load;
    load = (ex.aluop == ALU_LB) || (ex.aluop == ALU_LW);
    return load && ((c.reg1_read && ex.wd == c.reg1_addr) ||
                    (c.reg2_read && ex.wd == c.reg2_addr));
endfunction

task automatic model_branch(input dec_ctrl_t c, input logic [31:0] pc,
                            input logic [31:0] r1, input logic [31:0] r2,
                            output logic flag, output logic [31:0] tgt,
                            output logic [31:0] link);
    logic [31:0] pc4;
    pc4 = pc + 32'd4;
    flag = 1'b0;
    tgt = '0;
    link = '0;
    case (c.aluop)
        ALU_J, ALU_JAL: begin
            flag = 1'b1;
            tgt = {pc4[31:28], c.imm[25:0], 2'b00};
        end
        ALU_JR, ALU_JALR: begin
            flag = 1'b1;
            tgt = r1;
        end
        ALU_BEQ:  flag = (r1 == r2);
        ALU_BNE:  flag = (r1 != r2);
        ALU_BGTZ: flag = ($signed(r1) > 0);
        ALU_BLEZ: flag = ($signed(r1) <= 0);
        default:  flag = 1'b0;
    endcase
    if (flag && tgt == '0 && c.aluop != ALU_JR && c.aluop != ALU_JALR &&
        c.aluop != ALU_J && c.aluop != ALU_JAL) begin
        tgt = pc4 + {c.imm[29:0], 2'b00};
    end
    if (c.aluop == ALU_JAL || c.aluop == ALU_JALR) link = pc + 32'd8;
endtask

`endif

// File: bench/tb_id_stage.sv
module tb_id_stage
    import id_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INST = 2000;
    localparam int LIMIT = NUM_INST * 2 + 100;

    // {opcode, funct} of every kept instruction
    localparam logic [11:0] KEPT [35] = '{
        12'h000, 12'h002, 12'h003, 12'h004, 12'h006, 12'h007, 12'h008, 12'h009,
        12'h020, 12'h021, 12'h022, 12'h023, 12'h024, 12'h025, 12'h026, 12'h027,
        12'h02A, 12'h02B, 12'h080, 12'h0C0, 12'h100, 12'h140, 12'h180, 12'h1C0,
        12'h200, 12'h240, 12'h280, 12'h2C0, 12'h300, 12'h340, 12'h380, 12'h3C0,
        12'h800, 12'h8C0, 12'hAC0
    };

    logic clk;
    logic reset_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic is_in_delayslot_i;
    fwd_t ex_fwd_i;
    fwd_t mem_fwd_i;
    logic [31:0] rf1_data_i;
    logic [31:0] rf2_data_i;
    logic rf1_read_o;
    logic [4:0] rf1_addr_o;
    logic rf2_read_o;
    logic [4:0] rf2_addr_o;
    logic stall_o;
    logic branch_flag_o;
    logic [31:0] branch_target_o;
    logic next_in_delayslot_o;
    id_ex_t id_ex_o;

    logic [31:0] rf [0:31];
    logic [31:0] lfsr_state = 32'hfc95201d;
    int errors = 0;
    int checks = 0;
    int issued = 0;
    int cycles = 0;

    `include "id_model.svh"

    id_stage u_id_stage (.*);

    assign rf1_data_i = rf[rf1_addr_o];  // register file answers at once
    assign rf2_data_i = rf[rf2_addr_o];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [31:0] idx;
        r = take_bits(32);
        idx = take_bits(6) % 39;
        if (idx < 35) begin
            return {KEPT[idx][11:6], r[25:6],
                    (KEPT[idx][11:6] == 6'h00) ? KEPT[idx][5:0] : r[5:0]};
        end
        if (idx < 37) return {6'h3F, r[25:0]};  // unused opcode
        return {6'h00, r[25:6], 6'h3F};         // unused funct
    endfunction

    // forward source biased toward rs and rt
    function automatic fwd_t rand_fwd(input logic [31:0] inst);
        fwd_t f;
        logic [31:0] r;
        logic [31:0] pick;
        r = take_bits(1);
        f.wreg = r[0];
        pick = take_bits(2);
        r = take_bits(5);
        f.wd = (pick[1:0] == 2'd0) ? inst[25:21] : (pick[1:0] == 2'd1) ? inst[20:16] : r[4:0];
        f.wdata = take_bits(32);
        r = take_bits(3);
        f.aluop = (r[2:0] == 3'd0) ? ALU_LB : (r[2:0] == 3'd1) ? ALU_LW : ALU_ADDU;
        return f;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_id_ex(input id_ex_t exp);
        check_val("id_ex_o.aluop", 32'(id_ex_o.aluop), 32'(exp.aluop));
        check_val("id_ex_o.alusel", 32'(id_ex_o.alusel), 32'(exp.alusel));
        check_val("id_ex_o.reg1", id_ex_o.reg1, exp.reg1);
        check_val("id_ex_o.reg2", id_ex_o.reg2, exp.reg2);
        check_val("id_ex_o.wd", 32'(id_ex_o.wd), 32'(exp.wd));
        check_val("id_ex_o.wreg", 32'(id_ex_o.wreg), 32'(exp.wreg));
        check_val("id_ex_o.link_addr", id_ex_o.link_addr, exp.link_addr);
        check_val("id_ex_o.is_in_delayslot", 32'(id_ex_o.is_in_delayslot),
                  32'(exp.is_in_delayslot));
    endtask

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0] cur_inst;
        logic [31:0] cur_pc;
        logic cur_ds;
        fwd_t cur_ex;
        fwd_t cur_mem;
        dec_ctrl_t ec;
        logic [31:0] e1;
        logic [31:0] e2;
        logic est;
        logic ef;
        logic [31:0] et;
        logic [31:0] el;
        logic [31:0] r;
        id_ex_t exp_idex;
        logic have_exp;
        logic stalled;
        reset_i = 1'b1;
        inst_i = '0;
        pc_i = '0;
        is_in_delayslot_i = 1'b0;
        ex_fwd_i = '0;
        mem_fwd_i = '0;
        for (int i = 0; i < 32; i++) rf[i] = take_bits(32);
        cur_inst = '0;
        cur_pc = '0;
        cur_ds = 1'b0;
        have_exp = 1'b0;
        stalled = 1'b0;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_id_ex('0);  // bubble out of reset
        while (issued < NUM_INST) begin
            @(posedge clk);
            if (!stalled) begin  // upstream holds a stalled instruction
                cur_inst = gen_inst();
                cur_pc = take_bits(32);
                r = take_bits(1);
                cur_ds = r[0];
            end
            cur_ex = rand_fwd(cur_inst);
            cur_mem = rand_fwd(cur_inst);
            inst_i <= cur_inst;
            pc_i <= cur_pc;
            is_in_delayslot_i <= cur_ds;
            ex_fwd_i <= cur_ex;
            mem_fwd_i <= cur_mem;
            @(negedge clk);
            if (have_exp) check_id_ex(exp_idex);
            ec = model_decode(cur_inst);
            e1 = model_operand(ec.reg1_read, ec.reg1_addr, rf[ec.reg1_addr], ec.imm,
                               cur_ex, cur_mem);
            e2 = model_operand(ec.reg2_read, ec.reg2_addr, rf[ec.reg2_addr], ec.imm,
                               cur_ex, cur_mem);
            est = model_stall(ec, cur_ex);
            model_branch(ec, cur_pc, e1, e2, ef, et, el);
            check_val("rf1_read_o", 32'(rf1_read_o), 32'(ec.reg1_read));
            check_val("rf1_addr_o", 32'(rf1_addr_o), 32'(ec.reg1_addr));
            check_val("rf2_read_o", 32'(rf2_read_o), 32'(ec.reg2_read));
            check_val("rf2_addr_o", 32'(rf2_addr_o), 32'(ec.reg2_addr));
            check_val("stall_o", 32'(stall_o), 32'(est));
            if (!est) begin
                check_val("branch_flag_o", 32'(branch_flag_o), 32'(ef));
                check_val("branch_target_o", branch_target_o, et);
                check_val("next_in_delayslot_o", 32'(next_in_delayslot_o), 32'(ef));
                issued++;
            end
            exp_idex = '0;
            if (!est) begin
                exp_idex.aluop = ec.aluop;
                exp_idex.alusel = ec.alusel;
                exp_idex.reg1 = e1;
                exp_idex.reg2 = e2;
                exp_idex.wd = ec.wd;
                exp_idex.wreg = ec.wreg;
                exp_idex.link_addr = el;
                exp_idex.is_in_delayslot = cur_ds;
            end
            have_exp = 1'b1;
            stalled = est;
        end
        @(posedge clk);
        @(negedge clk);
        check_id_ex(exp_idex);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+bench
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_operand_sel.sv
hw/id_branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
bench/tb_id_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_id_stage -o sim_id_stage
./obj_dir/sim_id_stage > sim.log 2>&1
if grep -q "All tests passed!" sim.log; then
    echo "PASS"
else
    echo "FAIL, see sim.log"
    exit 1
fi
